// ==== vlog.f ====
src/conv_pkg.sv
src/conv_pixel_loop.sv
src/conv_weight_mul.sv
src/conv_channel_adder.sv
src/conv_out_align.sv
src/conv_1x1_layer.sv
test/tb_conv_1x1_layer.sv

// ==== Makefile ====
# Verilator build and run of the 1x1 convolution layer testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_conv_1x1_layer -o sim_tb

run: compile
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_conv_1x1_layer.sv ====
`timescale 1ns/10ps

module tb_conv_1x1_layer import conv_pkg::*; ();

  localparam int CIN        = 4;
  localparam int COUT       = 3;
  localparam int DEPTH      = 8;
  localparam int PIXEL_NUM  = 8;
  localparam int W_NUM      = CIN * COUT;
  localparam int RES_NUM    = PIXEL_NUM * COUT;
  localparam int PIXEL_GAP  = W_NUM;
  localparam int ROW_NUM    = 4;
  localparam int ROW_CYCLES = 16 + 12 + PIXEL_NUM * 12 + 60;
  localparam int CLK_PERIOD = 4;
  localparam logic [15:0] LFSR_SEED = 16'd85;

  // Weight and pixel modes of the table
  localparam int W_IDENT = 0;
  localparam int W_RAND  = 1;
  localparam int W_MAX   = 2;
  localparam int P_RAND  = 0;
  localparam int P_POS   = 1;
  localparam int P_NEG   = 2;

  logic                  clk;
  logic                  reset;
  logic                  valid_in;
  logic [DATA_WIDTH-1:0] pxl_in;
  logic                  valid_weight_in;
  logic [DATA_WIDTH-1:0] weight_in;
  logic [DATA_WIDTH-1:0] pxl_out;
  logic                  valid_out;

  // Test table
  int    wmode_tab [ROW_NUM];
  int    pmode_tab [ROW_NUM];
  string label_tab [ROW_NUM];

  logic [15:0]           lfsr_state;
  logic [DATA_WIDTH-1:0] weights [W_NUM];
  logic [DATA_WIDTH-1:0] pixels [PIXEL_NUM][CIN];
  logic [DATA_WIDTH-1:0] expected [RES_NUM];
  logic [DATA_WIDTH-1:0] got [$];

  logic streaming;
  logic first_seen;
  int   pixels_sent;
  int   replay_edges;
  int   quiet_errs;
  int   align_errs;
  int   rows_ok;
  int   rows_bad;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  conv_1x1_layer #(
    .CHANNEL_NUM_IN (CIN),
    .CHANNEL_NUM_OUT(COUT),
    .ALIGN_DEPTH    (DEPTH)
  ) u_conv_1x1_layer (
    .clk            (clk),
    .reset          (reset),
    .valid_in       (valid_in),
    .pxl_in         (pxl_in),
    .valid_weight_in(valid_weight_in),
    .weight_in      (weight_in),
    .pxl_out        (pxl_out),
    .valid_out      (valid_out)
  );

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////

  // 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[b]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic longint clamp_word(input longint x);
    if (x > longint'(DATA_MAX)) begin
      return longint'(DATA_MAX);
    end else if (x < longint'(DATA_MIN)) begin
      return longint'(DATA_MIN);
    end
    return x;
  endfunction

  task automatic make_stimulus(input int wmode, input int pmode);
    logic [15:0] r;
    for (int o = 0; o < COUT; o++) begin
      for (int i = 0; i < CIN; i++) begin
        case (wmode)
          W_IDENT: weights[o*CIN+i] = (i == o) ? 16'h0100 : 16'h0000;
          W_RAND: begin
            take_bits(16, r);
            weights[o*CIN+i] = r;
          end
          default: weights[o*CIN+i] = 16'h7FFF;
        endcase
      end
    end
    for (int k = 0; k < PIXEL_NUM; k++) begin
      for (int i = 0; i < CIN; i++) begin
        take_bits((pmode == P_RAND) ? 16 : 8, r);
        case (pmode)
          P_POS:   pixels[k][i] = {8'h70, r[7:0]};
          P_NEG:   pixels[k][i] = {8'h80, r[7:0]};
          default: pixels[k][i] = r;
        endcase
      end
    end
  endtask

  // Floor-shifted products clamped to a word, summed, clamped again
  task automatic build_expected();
    longint p;
    longint w;
    longint acc;
    for (int k = 0; k < PIXEL_NUM; k++) begin
      for (int o = 0; o < COUT; o++) begin
        acc = 0;
        for (int i = 0; i < CIN; i++) begin
          p   = longint'($signed(pixels[k][i]));
          w   = longint'($signed(weights[o*CIN+i]));
          acc = acc + clamp_word((p * w) >>> FRAC_BITS);
        end
        expected[k*COUT+o] = DATA_WIDTH'(clamp_word(acc));
      end
    end
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset           = 1'b1;
    valid_in        = 1'b0;
    valid_weight_in = 1'b0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic load_weights();
    for (int j = 0; j < W_NUM; j++) begin
      @(posedge clk);
      #1;
      valid_weight_in = 1'b1;
      weight_in       = weights[j];
    end
    @(posedge clk);
    #1 valid_weight_in = 1'b0;
  endtask

  // One pixel per replay length, so a bank is always free
  task automatic send_pixels();
    for (int k = 0; k < PIXEL_NUM; k++) begin
      for (int c = 0; c < PIXEL_GAP; c++) begin
        @(posedge clk);
        #1;
        valid_in = (c < CIN);
        if (c < CIN) begin
          pxl_in = pixels[k][c];
        end
        if (c == CIN - 1) begin
          pixels_sent++;
        end
      end
    end
    @(posedge clk);
    #1 valid_in = 1'b0;
  endtask

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  // Edges since the first pixel's last word was taken
  // Replay runs back to back from there at this pixel rate
  always @(posedge clk) begin
    if (streaming && pixels_sent > 0) begin
      replay_edges++;
    end
  end

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (valid_out) begin
      if (!streaming) begin
        quiet_errs++;
        $display("FAIL %0t: valid_out high during reset or weight load", $time);
      end else begin
        // Each result needs one finished replay group
        if (!first_seen) begin
          first_seen = 1'b1;
          if ((replay_edges - 1) / CIN < DEPTH) begin
            align_errs++;
            $display("output started after only %0d replay groups had finished",
                     (replay_edges - 1) / CIN);
          end
        end
        got.push_back(pxl_out);
      end
    end
  end

  task automatic check_row(input int r);
    int errs;
    errs = quiet_errs + align_errs;
    if (got.size() != RES_NUM) begin
      errs++;
      $display("row %0d: expected %0d results but received %0d", r, RES_NUM, got.size());
    end
    for (int n = 0; n < RES_NUM && n < got.size(); n++) begin
      if (got[n] !== expected[n]) begin
        errs++;
        $display("FAIL %0t: row %0d index %0d expected %h actual %h",
                 $time, r, n, expected[n], got[n]);
      end
    end
    if (errs == 0) begin
      rows_ok++;
      $display("row %0d %s: ok", r, label_tab[r]);
    end else begin
      rows_bad++;
      $display("row %0d %s: %0d errors", r, label_tab[r], errs);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    streaming       = 1'b0;
    first_seen      = 1'b0;
    pixels_sent     = 0;
    replay_edges    = 0;
    quiet_errs      = 0;
    align_errs      = 0;
    rows_ok         = 0;
    rows_bad        = 0;
    lfsr_state      = LFSR_SEED;

    wmode_tab[0] = W_IDENT;
    pmode_tab[0] = P_RAND;
    label_tab[0] = "identity";
    wmode_tab[1] = W_RAND;
    pmode_tab[1] = P_RAND;
    label_tab[1] = "random";
    wmode_tab[2] = W_MAX;
    pmode_tab[2] = P_POS;
    label_tab[2] = "saturate high";
    wmode_tab[3] = W_MAX;
    pmode_tab[3] = P_NEG;
    label_tab[3] = "saturate low";

    for (int r = 0; r < ROW_NUM; r++) begin
      streaming    = 1'b0;
      first_seen   = 1'b0;
      pixels_sent  = 0;
      replay_edges = 0;
      quiet_errs   = 0;
      align_errs   = 0;
      got.delete();
      apply_reset();
      make_stimulus(wmode_tab[r], pmode_tab[r]);
      build_expected();
      load_weights();
      streaming = 1'b1;
      send_pixels();
      // Drain, then an idle window to catch extra words
      while (got.size() < RES_NUM) begin
        @(posedge clk);
      end
      repeat (24) @(posedge clk);
      check_row(r);
    end

    $display("rows passed %0d, rows failed %0d", rows_ok, rows_bad);
    if (rows_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the row length
  initial begin
    #(ROW_NUM * ROW_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", ROW_NUM * ROW_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// ==== src/conv_1x1_layer.sv ====
`timescale 1ns/10ps

module conv_1x1_layer import conv_pkg::*; #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 3,
  parameter int ALIGN_DEPTH     = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] pxl_in,
  input  logic                  valid_weight_in,
  input  logic [DATA_WIDTH-1:0] weight_in,
  output logic [DATA_WIDTH-1:0] pxl_out,
  output logic                  valid_out
);

  // Replayed pixel words
  logic                  loop_valid;
  logic [DATA_WIDTH-1:0] loop_pxl;
  // Weighted words
  logic                  prod_valid;
  logic [DATA_WIDTH-1:0] prod;
  // One result per output channel
  logic                  sum_valid;
  logic [DATA_WIDTH-1:0] sum_pxl;

  conv_pixel_loop #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
  ) u_conv_pixel_loop (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .loop_valid(loop_valid),
    .loop_pxl  (loop_pxl)
  );

  conv_weight_mul #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
  ) u_conv_weight_mul (
    .clk            (clk),
    .reset          (reset),
    .valid_weight_in(valid_weight_in),
    .weight_in      (weight_in),
    .loop_valid     (loop_valid),
    .loop_pxl       (loop_pxl),
    .prod_valid     (prod_valid),
    .prod           (prod)
  );

  conv_channel_adder #(
    .CHANNEL_NUM_IN(CHANNEL_NUM_IN)
  ) u_conv_channel_adder (
    .clk       (clk),
    .reset     (reset),
    .prod_valid(prod_valid),
    .prod      (prod),
    .sum_valid (sum_valid),
    .sum_pxl   (sum_pxl)
  );

  conv_out_align #(
    .ALIGN_DEPTH(ALIGN_DEPTH)
  ) u_conv_out_align (
    .clk      (clk),
    .reset    (reset),
    .sum_valid(sum_valid),
    .sum_pxl  (sum_pxl),
    .pxl_out  (pxl_out),
    .valid_out(valid_out)
  );

endmodule

// ==== src/conv_out_align.sv ====
`timescale 1ns/10ps

module conv_out_align import conv_pkg::*; #(
  parameter int ALIGN_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sum_valid,
  input  logic [DATA_WIDTH-1:0] sum_pxl,
  output logic [DATA_WIDTH-1:0] pxl_out,
  output logic                  valid_out
);

  localparam int PTR_W = (ALIGN_DEPTH > 1) ? $clog2(ALIGN_DEPTH) : 1;
  localparam int CNT_W = $clog2(ALIGN_DEPTH + 1);

  logic [DATA_WIDTH-1:0] fifo_mem [ALIGN_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             fifo_full;
  logic             fifo_empty;
  logic             read_en;
  logic             wr;
  logic             rd;

  assign fifo_full  = (count == CNT_W'(ALIGN_DEPTH));
  assign fifo_empty = (count == '0);
  assign wr         = sum_valid;
  // Drain only after the first fill
  assign rd         = read_en && !fifo_empty;

  ////////////////////////////////////////
  // FIFO storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr) begin
      fifo_mem[wr_ptr] <= sum_pxl;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(ALIGN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(ALIGN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy moves only when one side is active
      if (wr && !rd) begin
        count <= count + 1'b1;
      end else if (rd && !wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Sticky start flag, cleared only by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      read_en <= 1'b0;
    end else if (fifo_full) begin
      read_en <= 1'b1;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      pxl_out <= fifo_mem[rd_ptr];
    end
  end

  // No result may land in a full FIFO unless one leaves
  a_no_fifo_overflow: assert property (
    @(posedge clk) disable iff (reset) (wr && fifo_full) |-> rd
  ) else $error("output FIFO overflow");

endmodule

// ==== src/conv_channel_adder.sv ====
`timescale 1ns/10ps

module conv_channel_adder import conv_pkg::*; #(
  parameter int CHANNEL_NUM_IN = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  prod_valid,
  input  logic [DATA_WIDTH-1:0] prod,
  output logic                  sum_valid,
  output logic [DATA_WIDTH-1:0] sum_pxl
);

  localparam int CIN_W = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;

  logic [CIN_W-1:0]            cnt;
  logic                        group_last;
  logic signed [ACC_WIDTH-1:0] prod_ext;
  logic signed [ACC_WIDTH-1:0] acc;
  logic signed [ACC_WIDTH-1:0] acc_next;
  logic signed [DATA_WIDTH-1:0] sum_sat;

  // Sign extension into the wide accumulator
  assign prod_ext   = $signed(prod);
  assign acc_next   = acc + prod_ext;
  assign group_last = (cnt == CIN_W'(CHANNEL_NUM_IN - 1));

  // Clamp group total to the result range
  always_comb begin
    if (acc_next > DATA_MAX) begin
      sum_sat = DATA_MAX;
    end else if (acc_next < DATA_MIN) begin
      sum_sat = DATA_MIN;
    end else begin
      sum_sat = acc_next[DATA_WIDTH-1:0];
    end
  end

  // Group counter and accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt       <= '0;
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid && group_last;
      if (prod_valid) begin
        if (group_last) begin
          // Restart from zero for the next output channel
          cnt <= '0;
          acc <= '0;
        end else begin
          cnt <= cnt + 1'b1;
          acc <= acc_next;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid && group_last) begin
      sum_pxl <= sum_sat;
    end
  end

endmodule

// ==== src/conv_weight_mul.sv ====
`timescale 1ns/10ps

module conv_weight_mul import conv_pkg::*; #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_weight_in,
  input  logic [DATA_WIDTH-1:0] weight_in,
  input  logic                  loop_valid,
  input  logic [DATA_WIDTH-1:0] loop_pxl,
  output logic                  prod_valid,
  output logic [DATA_WIDTH-1:0] prod
);

  localparam int W_NUM = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
  localparam int PTR_W = (W_NUM > 1) ? $clog2(W_NUM) : 1;

  // Output channel major, input channel minor
  logic [DATA_WIDTH-1:0] weight_mem [W_NUM];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  logic signed [PROD_WIDTH-1:0] prod_full;
  logic signed [PROD_WIDTH-1:0] prod_shift;
  logic signed [DATA_WIDTH-1:0] prod_sat;

  ////////////////////////////////////////
  // Weight load
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      weight_mem[wr_ptr] <= weight_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (valid_weight_in) begin
      if (wr_ptr == PTR_W'(W_NUM - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////

  // Read index follows replay order, one step per word
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (loop_valid) begin
      if (rd_ptr == PTR_W'(W_NUM - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign prod_full  = $signed(loop_pxl) * $signed(weight_mem[rd_ptr]);
  // Arithmetic shift back to Q8.8, floor rounding
  assign prod_shift = prod_full >>> FRAC_BITS;

  // Clamp to the data word so the prod port keeps its sign
  always_comb begin
    if (prod_shift > DATA_MAX) begin
      prod_sat = DATA_MAX;
    end else if (prod_shift < DATA_MIN) begin
      prod_sat = DATA_MIN;
    end else begin
      prod_sat = prod_shift[DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= loop_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (loop_valid) begin
      prod <= prod_sat;
    end
  end

  // Weights are loaded between images, never during replay
  a_no_load_in_replay: assert property (
    @(posedge clk) disable iff (reset) !(valid_weight_in && loop_valid)
  ) else $error("weight write while loop buffer is replaying");

endmodule

// ==== src/conv_pixel_loop.sv ====
`timescale 1ns/10ps

module conv_pixel_loop import conv_pkg::*; #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] pxl_in,
  output logic                  loop_valid,
  output logic [DATA_WIDTH-1:0] loop_pxl
);

  localparam int CIN_W  = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
  localparam int COUT_W = (CHANNEL_NUM_OUT > 1) ? $clog2(CHANNEL_NUM_OUT) : 1;

  // Two banks, each holding one pixel's input channels
  logic [DATA_WIDTH-1:0] bank_mem [2][CHANNEL_NUM_IN];
  logic [1:0]            bank_full;

  // Capture side
  logic [CIN_W-1:0] fill_ptr;
  logic             fill_bank;
  logic             fill_done;

  // Replay side
  logic              rep_active;
  logic              rep_bank;
  logic [CIN_W-1:0]  rep_in_cnt;
  logic [COUT_W-1:0] rep_out_cnt;
  logic              rep_in_last;
  logic              rep_done;
  logic              next_bank;
  logic              next_ready;
  logic              bank_busy;

  ////////////////////////////////////////
  // Capture
  ////////////////////////////////////////

  // Last input channel of a pixel
  assign fill_done = valid_in && (fill_ptr == CIN_W'(CHANNEL_NUM_IN - 1));

  always_ff @(posedge clk) begin
    if (valid_in) begin
      bank_mem[fill_bank][fill_ptr] <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_ptr  <= '0;
      fill_bank <= 1'b0;
    end else if (valid_in) begin
      if (fill_done) begin
        fill_ptr  <= '0;
        fill_bank <= ~fill_bank;
      end else begin
        fill_ptr <= fill_ptr + 1'b1;
      end
    end
  end

  // Bank is full from its last word until its last replay word
  always_ff @(posedge clk) begin
    if (reset) begin
      bank_full <= 2'b00;
    end else begin
      if (rep_done) begin
        bank_full[rep_bank] <= 1'b0;
      end
      if (fill_done) begin
        bank_full[fill_bank] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Replay
  ////////////////////////////////////////

  assign rep_in_last = (rep_in_cnt == CIN_W'(CHANNEL_NUM_IN - 1));
  assign rep_done    = rep_active && rep_in_last &&
                       (rep_out_cnt == COUT_W'(CHANNEL_NUM_OUT - 1));

  // Banks replay in fill order; idle means rep_bank is next
  assign next_bank  = rep_active ? ~rep_bank : rep_bank;
  // Ready if already full or completing on this edge
  assign next_ready = bank_full[next_bank] || (fill_done && (fill_bank == next_bank));

  always_ff @(posedge clk) begin
    if (reset) begin
      rep_active  <= 1'b0;
      rep_bank    <= 1'b0;
      rep_in_cnt  <= '0;
      rep_out_cnt <= '0;
    end else if (rep_active) begin
      if (rep_in_last) begin
        rep_in_cnt <= '0;
        if (rep_done) begin
          // Hand over straight to the other bank when it is waiting
          rep_out_cnt <= '0;
          rep_bank    <= ~rep_bank;
          rep_active  <= next_ready;
        end else begin
          rep_out_cnt <= rep_out_cnt + 1'b1;
        end
      end else begin
        rep_in_cnt <= rep_in_cnt + 1'b1;
      end
    end else if (next_ready) begin
      rep_active <= 1'b1;
    end
  end

  assign loop_valid = rep_active;
  assign loop_pxl   = bank_mem[rep_bank][rep_in_cnt];

  // Bank still in use unless its final replay read is on this edge
  assign bank_busy = bank_full[fill_bank] && !(rep_done && (rep_bank == fill_bank));

  // Source spacing: no word into a bank that is still replaying
  a_no_bank_overrun: assert property (
    @(posedge clk) disable iff (reset) valid_in |-> !bank_busy
  ) else $error("pixel loop overrun, bank %0d still full", fill_bank);

endmodule

// ==== src/conv_pkg.sv ====
// Shared fixed-point definitions for the 1x1 convolution layer

package conv_pkg;

  ////////////////////////////////////////
  // Word format
  ////////////////////////////////////////

  // Signed Q8.8 for pixels, weights and results
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;

  // Full signed product of two data words
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  // Product width plus 6 guard bits, room for 64 input channels
  localparam int ACC_WIDTH = PROD_WIDTH + 6;

  ////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////

  // Largest positive result word
  localparam logic signed [DATA_WIDTH-1:0] DATA_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};

  // Most negative result word
  localparam logic signed [DATA_WIDTH-1:0] DATA_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

endpackage
